// File: Makefile
TOP := fetch_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 --top-module $(TOP) -f sim.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/core_fsm.sv
module core_fsm (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  instr_valid_i,
    input  logic                  hazard_i,
    output core_pkg::core_phase_e phase_o,
    output logic                  retire_o
);

    import core_pkg::*;

    core_phase_e phase_q;
    core_phase_e phase_d;

    // ########################################
    // Phase sequencing
    // ########################################

    always_comb begin
        phase_d = phase_q;
        unique case (phase_q)
            PH_IF:  if (instr_valid_i) phase_d = PH_ID; // Wait for the fetch stage.
            PH_ID:  phase_d = PH_EX;
            PH_EX:  phase_d = PH_MEM;
            PH_MEM: phase_d = PH_WB;
            PH_WB:  if (!hazard_i) phase_d = PH_IF;
            default: phase_d = PH_IF;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            phase_q <= PH_IF;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign phase_o = phase_q;

    // Retire marks the single WB cycle that moves on.
    assign retire_o = (phase_q == PH_WB) && !hazard_i;

endmodule : core_fsm

// File: hdl/core_pkg.sv
package core_pkg;

    // ########################################
    // Word and address sizes
    // ########################################

    localparam int WORD_SIZE = 32; // Instruction and data width.
    localparam int ADDR_SIZE = 32; // Byte address width.

    // ########################################
    // Core phases
    // ########################################

    // The sequencer walks these in order and returns to PH_IF after WB.
    typedef enum logic [2:0] {
        PH_IF,
        PH_ID,
        PH_EX,
        PH_MEM,
        PH_WB
    } core_phase_e;

endpackage : core_pkg

// File: hdl/fetch_top.sv
module fetch_top (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            hazard_i,
    input  logic                            tkbr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0]  new_pc_i,
    input  logic                            flush_i,
    input  logic                            mem_valid_i,
    input  logic [icache_pkg::LINE_BITS-1:0] mem_line_i,
    output logic [core_pkg::ADDR_SIZE-1:0]  pc_o,
    output logic [core_pkg::WORD_SIZE-1:0]  instr_o,
    output logic                            instr_valid_o,
    output core_pkg::core_phase_e           phase_o,
    output logic                            mem_rd_o,
    output logic [core_pkg::ADDR_SIZE-1:0]  mem_addr_o
);

    import core_pkg::*;

    core_phase_e phase;
    logic        retire;
    logic        instr_valid;

    // The sequencer waits on the fetch stage in IF and releases it in WB.
    core_fsm u_core_fsm (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid),
        .hazard_i      (hazard_i),
        .phase_o       (phase),
        .retire_o      (retire)
    );

    if_stage u_if_stage (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .phase_i       (phase),
        .retire_i      (retire),
        .tkbr_i        (tkbr_i),
        .new_pc_i      (new_pc_i),
        .flush_i       (flush_i),
        .mem_valid_i   (mem_valid_i),
        .mem_line_i    (mem_line_i),
        .pc_o          (pc_o),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid),
        .mem_rd_o      (mem_rd_o),
        .mem_addr_o    (mem_addr_o)
    );

    assign phase_o       = phase;
    assign instr_valid_o = instr_valid;

endmodule : fetch_top

// File: hdl/icache_data.sv
module icache_data (
    input  logic                              clk_i,
    input  logic [icache_pkg::INDEX_BITS-1:0]    index_i,
    input  logic [icache_pkg::WORD_OFF_BITS-1:0] word_i,
    input  logic                              fill_i,
    input  logic [icache_pkg::LINE_BITS-1:0]     line_i,
    output logic [core_pkg::WORD_SIZE-1:0]       word_o
);

    import core_pkg::*;
    import icache_pkg::*;

    logic [LINE_BITS-1:0] lines [SETS];
    logic [WORD_SIZE-1:0] word_q;

    // ########################################
    // Line write on refill
    // ########################################

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines[index_i] <= line_i; // The whole line lands at once.
        end
    end

    // ########################################
    // Word read
    // ########################################

    // Read runs every cycle. A read on the fill edge still returns the old line,
    // which is why the fetch stage waits one idle cycle before its retry.
    always_ff @(posedge clk_i) begin
        word_q <= lines[index_i][word_i*WORD_SIZE +: WORD_SIZE];
    end

    assign word_o = word_q;

endmodule : icache_data

// File: hdl/icache_pkg.sv
package icache_pkg;

    // ########################################
    // Cache geometry
    // ########################################

    localparam int LINE_WORDS    = 4;
    localparam int LINE_BITS     = LINE_WORDS * core_pkg::WORD_SIZE;
    localparam int SETS          = 16;
    localparam int OFFSET_BITS   = 4;                // Word offset plus byte offset.
    localparam int INDEX_BITS    = $clog2(SETS);
    localparam int TAG_BITS      = core_pkg::ADDR_SIZE - INDEX_BITS - OFFSET_BITS;
    localparam int WORD_OFF_BITS = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_BITS = OFFSET_BITS - WORD_OFF_BITS;

    // ########################################
    // Fetch address
    // ########################################

    // One address word, seen either as a plain byte address or split into cache fields.
    typedef union packed {
        logic [core_pkg::ADDR_SIZE-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]      tag;
            logic [INDEX_BITS-1:0]    index;
            logic [WORD_OFF_BITS-1:0] woff;
            logic [BYTE_OFF_BITS-1:0] boff;
        } f;
    } fetch_addr_u;

endpackage : icache_pkg

// File: hdl/icache_tag.sv
module icache_tag (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           req_i,
    input  logic [icache_pkg::INDEX_BITS-1:0] index_i,
    input  logic [icache_pkg::TAG_BITS-1:0]   tag_i,
    input  logic                           fill_i,
    input  logic                           flush_i,
    output logic                           hit_o,
    output logic                           miss_o
);

    import icache_pkg::*;

    logic [TAG_BITS-1:0] tags [SETS];
    logic [SETS-1:0]     valid_q;
    logic                match;
    logic                hit_q;
    logic                miss_q;

    assign match = valid_q[index_i] && (tags[index_i] == tag_i);

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags[index_i] <= tag_i;
        end
    end

    // A fill on the flush edge keeps its own line, since that data is fresh.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (flush_i) valid_q <= '0;
            if (fill_i) valid_q[index_i] <= 1'b1;
        end
    end

    // The lookup result is registered. A flush in the same cycle forces a miss.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            hit_q  <= req_i && match && !flush_i;
            miss_q <= req_i && (!match || flush_i);
        end
    end

    assign hit_o  = hit_q;
    assign miss_o = miss_q;

endmodule : icache_tag

// File: hdl/if_stage.sv
module if_stage (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  core_pkg::core_phase_e           phase_i,
    input  logic                            retire_i,
    input  logic                            tkbr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0]  new_pc_i,
    input  logic                            flush_i,
    input  logic                            mem_valid_i,
    input  logic [icache_pkg::LINE_BITS-1:0] mem_line_i,
    output logic [core_pkg::ADDR_SIZE-1:0]  pc_o,
    output logic [core_pkg::WORD_SIZE-1:0]  instr_o,
    output logic                            instr_valid_o,
    output logic                            mem_rd_o,
    output logic [core_pkg::ADDR_SIZE-1:0]  mem_addr_o
);

    import core_pkg::*;
    import icache_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, DONE} if_state_e;

    if_state_e   state_q;
    if_state_e   state_d;
    fetch_addr_u pc_q;
    fetch_addr_u line_addr;
    logic        tag_req;
    logic        tag_hit;
    logic        tag_miss;
    logic        fill;

    assign tag_req = (state_q == IDLE) && (phase_i == PH_IF);
    assign fill    = (state_q == REFILL) && mem_valid_i;

    icache_tag u_tag (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (tag_req),
        .index_i (pc_q.f.index),
        .tag_i   (pc_q.f.tag),
        .fill_i  (fill),
        .flush_i (flush_i),
        .hit_o   (tag_hit),
        .miss_o  (tag_miss)
    );

    icache_data u_data (
        .clk_i   (clk_i),
        .index_i (pc_q.f.index),
        .word_i  (pc_q.f.woff),
        .fill_i  (fill),
        .line_i  (mem_line_i),
        .word_o  (instr_o)
    );

    // ########################################
    // Miss and refill FSM
    // ########################################

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:   if (phase_i == PH_IF) state_d = LOOKUP;
            LOOKUP: begin
                if (tag_hit) state_d = DONE;
                else if (tag_miss) state_d = REFILL;
                else state_d = IDLE;
            end
            REFILL: if (mem_valid_i) state_d = IDLE; // Retry the lookup.
            DONE:   if (retire_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) state_q <= IDLE;
        else state_q <= state_d;
    end

    // The PC stays put until the instruction retires.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q.raw <= '0;
        end else if (retire_i) begin
            pc_q.raw <= tkbr_i ? new_pc_i : pc_q.raw + ADDR_SIZE'(4);
        end
    end

    always_comb begin
        line_addr        = pc_q;
        line_addr.f.woff = '0;
        line_addr.f.boff = '0;
    end

    assign pc_o          = pc_q.raw;
    assign instr_valid_o = (state_q == LOOKUP) && tag_hit;
    assign mem_rd_o      = (state_q == REFILL);
    assign mem_addr_o    = line_addr.raw;

endmodule : if_stage

// File: sim.f
hdl/core_pkg.sv
hdl/icache_pkg.sv
hdl/icache_tag.sv
hdl/icache_data.sv
hdl/if_stage.sv
hdl/core_fsm.sv
hdl/fetch_top.sv
tb/fetch_sva.sv
tb/fetch_tb.sv

// File: tb/fetch_sva.sv
module fetch_sva #(
    parameter logic [31:0] PATTERN = 32'h6b2f_d419
) (
    input logic                           clk_i,
    input logic                           reset_i,
    input logic                           hazard_i,
    input logic                           tkbr_i,
    input logic [core_pkg::ADDR_SIZE-1:0] new_pc_i,
    input logic                           flush_i,
    input logic                           mem_valid_i,
    input logic [core_pkg::ADDR_SIZE-1:0] pc_i,
    input logic [core_pkg::WORD_SIZE-1:0] instr_i,
    input logic                           instr_valid_i,
    input core_pkg::core_phase_e          phase_i,
    input logic                           mem_rd_i,
    input logic [core_pkg::ADDR_SIZE-1:0] mem_addr_i,
    input logic                           retire_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    int unsigned fail_cnt = 0;
    logic [31:0] set_line [16]; // Line address held by each of the 16 sets.
    logic [15:0] set_valid;
    logic        first_req;
    logic [31:0] pc_line;
    logic        expect_hit;

    assign pc_line    = {pc_i[31:4], 4'b0};
    assign expect_hit = set_valid[pc_i[7:4]] && (set_line[pc_i[7:4]] == pc_line);

    // Direct-mapped view of what has been filled since the last flush.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            set_valid <= '0;
            first_req <= 1'b1;
        end else begin
            if (flush_i) set_valid <= '0;
            if (mem_rd_i && mem_valid_i) begin
                set_line[mem_addr_i[7:4]]  <= mem_addr_i;
                set_valid[mem_addr_i[7:4]] <= 1'b1;
            end
            if (mem_rd_i) first_req <= 1'b0;
        end
    end

    // ########################################
    // Checks
    // ########################################

    a_reset: assert property (@(posedge clk_i) $fell(reset_i) |->
        pc_i == '0 && !mem_rd_i && !instr_valid_i && phase_i == PH_IF)
        else begin fail_cnt++; $error("ERR %0t: state after reset is wrong", $time); end

    a_first_addr: assert property (@(posedge clk_i) disable iff (reset_i)
        first_req && mem_rd_i |-> mem_addr_i == '0)
        else begin fail_cnt++; $error("ERR %0t: first request not at 0", $time); end

    a_req_addr: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rd_i |-> mem_addr_i == pc_line)
        else begin fail_cnt++; $error("ERR %0t: request address %h", $time, mem_addr_i); end

    a_instr: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> instr_i == (pc_i ^ PATTERN))
        else begin fail_cnt++; $error("ERR %0t: instr %h at pc %h", $time, instr_i, pc_i); end

    a_hit_filled: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> expect_hit)
        else begin fail_cnt++; $error("ERR %0t: hit on a line not filled", $time); end

    a_miss_unfilled: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(mem_rd_i) |-> !expect_hit)
        else begin fail_cnt++; $error("ERR %0t: request for a filled line", $time); end

    a_next_pc: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_i |=> pc_i == ($past(tkbr_i) ? $past(new_pc_i) : $past(pc_i) + 32'd4))
        else begin fail_cnt++; $error("ERR %0t: pc %h after retire", $time, pc_i); end

    a_hazard: assert property (@(posedge clk_i) disable iff (reset_i)
        (phase_i == PH_WB) && hazard_i |=> (phase_i == PH_WB) && $stable(pc_i))
        else begin fail_cnt++; $error("ERR %0t: hazard did not hold WB", $time); end

endmodule : fetch_sva

bind fetch_top fetch_sva u_sva (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .hazard_i      (hazard_i),
    .tkbr_i        (tkbr_i),
    .new_pc_i      (new_pc_i),
    .flush_i       (flush_i),
    .mem_valid_i   (mem_valid_i),
    .pc_i          (pc_o),
    .instr_i       (instr_o),
    .instr_valid_i (instr_valid_o),
    .phase_i       (phase_o),
    .mem_rd_i      (mem_rd_o),
    .mem_addr_i    (mem_addr_o),
    .retire_i      (retire)
);

// File: tb/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import icache_pkg::*;

    localparam int unsigned SEED         = 32'h8c64a02d;
    localparam logic [31:0] MEM_PATTERN  = 32'h6b2f_d419;
    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_LATENCY  = 8;
    localparam int          MAX_HAZARD   = 4;
    localparam int          TOTAL_INSTR  = 4 + 16 + 24 + 16 + 24; // Sum of the test lengths.

    logic                 clk_i = 1'b0;
    logic                 reset_i;
    logic                 hazard_i;
    logic                 tkbr_i;
    logic [ADDR_SIZE-1:0] new_pc_i;
    logic                 flush_i;
    logic                 mem_valid_i;
    logic [LINE_BITS-1:0] mem_line_i;
    logic [ADDR_SIZE-1:0] pc_o;
    logic [WORD_SIZE-1:0] instr_o;
    logic                 instr_valid_o;
    core_phase_e          phase_o;
    logic                 mem_rd_o;
    logic [ADDR_SIZE-1:0] mem_addr_o;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    fetch_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ########################################
    // Memory model
    // ########################################

    function automatic logic [LINE_BITS-1:0] fill_line(input logic [31:0] line_addr);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*WORD_SIZE +: WORD_SIZE] = (line_addr + 32'(4 * w)) ^ MEM_PATTERN;
        end
        return line;
    endfunction

    initial begin : memory_model
        int lat;
        mem_valid_i = 1'b0;
        mem_line_i  = '0;
        forever begin
            @(negedge clk_i);
            if (mem_rd_o) begin
                lat = int'($urandom_range(1, MAX_LATENCY));
                repeat (lat - 1) @(negedge clk_i);
                mem_line_i  = fill_line(mem_addr_o);
                mem_valid_i = 1'b1;
                @(negedge clk_i);
                mem_valid_i = 1'b0;
            end
        end
    end

    // ########################################
    // Stimulus
    // ########################################

    // One instruction. Branch, hazard and flush are set up once the fetch is done.
    task automatic step_instr(input bit branch, input logic [31:0] target, input int stall,
                              input bit flush);
        @(negedge clk_i);
        while (phase_o != PH_EX) @(negedge clk_i);
        flush_i  = flush;
        tkbr_i   = branch;
        new_pc_i = target;
        hazard_i = (stall > 0);
        @(negedge clk_i);
        flush_i = 1'b0;
        @(negedge clk_i);                   // Now in WB.
        repeat (stall) @(negedge clk_i);
        hazard_i = 1'b0;                    // This WB cycle retires.
        @(negedge clk_i);
        tkbr_i = 1'b0;
    endtask

    task automatic run_test(input string name, input int count, input bit branches,
                            input bit stalls, input bit flushes);
        int unsigned fails_before;
        bit          branch;
        logic [31:0] target;
        int          stall;
        bit          flush;
        fails_before = dut0.u_sva.fail_cnt;
        for (int i = 0; i < count; i++) begin
            branch = branches && ($urandom_range(0, 1) == 1);
            target = $urandom_range(0, 255) << 2; // Word aligned targets in 1 KB make tags alias.
            stall  = stalls ? int'($urandom_range(0, MAX_HAZARD)) : 0;
            flush  = flushes && ($urandom_range(0, 2) == 0);
            step_instr(branch, target, stall, flush);
        end
        tests_run++;
        if (dut0.u_sva.fail_cnt != fails_before) tests_failed++;
        $display("test %s: %0d instructions, pc %h, %0d assertion failures", name, count,
                 pc_o, dut0.u_sva.fail_cnt - fails_before);
    endtask

    initial begin
        void'($urandom(SEED));
        reset_i     = 1'b1;
        hazard_i    = 1'b0;
        tkbr_i      = 1'b0;
        new_pc_i    = '0;
        flush_i     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;

        run_test("reset", 4, 1'b0, 1'b0, 1'b0);
        run_test("sequential", 16, 1'b0, 1'b0, 1'b0);
        run_test("branch", 24, 1'b1, 1'b0, 1'b0);
        run_test("hazard", 16, 1'b1, 1'b1, 1'b0);
        run_test("flush", 24, 1'b1, 1'b0, 1'b1);

        $display("%0d tests run, %0d failing, %0d assertion failures", tests_run,
                 tests_failed, dut0.u_sva.fail_cnt);
        if (tests_failed == 0 && dut0.u_sva.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Worst case per instruction is a refill plus the longest hazard.
    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_INSTR * (MAX_LATENCY + MAX_HAZARD + 12)) @(posedge clk_i);
        $display("Timeout: the tests did not finish in the allowed number of cycles.");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : fetch_tb
